/* Makefile */
TOP = tbPipeCore

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP)

obj_dir/simv: tb.f *.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP) -o simv

sim: obj_dir/simv
	./obj_dir/simv | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* forwardControl.sv */
module forwardControl
	import mipsIsaPkg::*, fwdPkg::*;
(
	input logic [31:0] instrD,
	input logic [31:0] instrE,
	input logic [31:0] instrM,
	input logic [31:0] instrW,
	input logic [4:0] a3M,
	input logic [4:0] a3W,
	output fwdSelT cmp1Sel,
	output fwdSelT cmp2Sel,
	output fwdSelT aluASel,
	output fwdSelT aluBSel,
	output fwdSelT dmDataSel
);

	logic [4:0] rsD;
	logic [4:0] rtD;
	logic [4:0] rsE;
	logic [4:0] rtE;
	logic [4:0] rtM;
	resClassT classM;
	resClassT classW;

	assign rsD = instrD[rsMsb:rsLsb];
	assign rtD = instrD[rtMsb:rtLsb];
	assign rsE = instrE[rsMsb:rsLsb];
	assign rtE = instrE[rtMsb:rtLsb];

	instrDecode decM_i (.instr(instrM), .rs(), .rt(rtM), .a3(), .resClass(classM),
		.tuseRs(), .tuseRt());
	instrDecode decW_i (.instr(instrW), .rs(), .rt(), .a3(), .resClass(classW),
		.tuseRs(), .tuseRt());

	// M wins over W; a load still in M is left to the stall unit
	function automatic fwdSelT pickSel(input logic [4:0] src, input logic fromM,
			input fwdSelT mAlu, input fwdSelT mPc,
			input fwdSelT wAlu, input fwdSelT wDm, input fwdSelT wPc);
		fwdSelT sel;
		sel = selNone;
		if (src != '0) begin
			if (fromM && src == a3M && classM == resAlu) begin
				sel = mAlu;
			end else if (fromM && src == a3M && classM == resPc) begin
				sel = mPc;
			end else if (src == a3W && classW == resAlu) begin
				sel = wAlu;
			end else if (src == a3W && classW == resDm) begin
				sel = wDm;
			end else if (src == a3W && classW == resPc) begin
				sel = wPc;
			end
		end
		return sel;
	endfunction

	always_comb begin
		cmp1Sel = pickSel(rsD, 1'b1, selMdAlu, selMdPc, selWdAlu, selWdDm, selWdPc);
		cmp2Sel = pickSel(rtD, 1'b1, selMdAlu, selMdPc, selWdAlu, selWdDm, selWdPc);
		aluASel = pickSel(rsE, 1'b1, selMeAlu, selMePc, selWeAlu, selWeDm, selWePc);
		aluBSel = pickSel(rtE, 1'b1, selMeAlu, selMePc, selWeAlu, selWeDm, selWePc);
		// Store data only has W behind it
		dmDataSel = pickSel(rtM, 1'b0, selNone, selNone, selWmAlu, selWmDm, selWmPc);

		// Register 0 never takes a forwarded value
		assert (rsD != '0 || cmp1Sel == selNone);
		assert (rtD != '0 || cmp2Sel == selNone);
		assert (rsE != '0 || aluASel == selNone);
		assert (rtE != '0 || aluBSel == selNone);
		assert (rtM != '0 || dmDataSel == selNone);
	end

endmodule

/* fwdPkg.sv */
package fwdPkg;

	typedef logic [3:0] fwdSelT;
	typedef logic [1:0] useTimeT;

	////////////////////
	// Forwarding selects
	////////////////////

	// Register file or pipeline value
	localparam fwdSelT selNone = 4'd0;

	// Into the D-stage comparator
	localparam fwdSelT selMdAlu = 4'd1;
	localparam fwdSelT selMdPc = 4'd2;
	localparam fwdSelT selWdAlu = 4'd3;
	localparam fwdSelT selWdDm = 4'd4;
	localparam fwdSelT selWdPc = 4'd5;

	// Into the ALU operands
	localparam fwdSelT selMeAlu = 4'd6;
	localparam fwdSelT selMePc = 4'd7;
	localparam fwdSelT selWeAlu = 4'd8;
	localparam fwdSelT selWeDm = 4'd9;
	localparam fwdSelT selWePc = 4'd10;

	// Into the M-stage store data
	localparam fwdSelT selWmAlu = 4'd11;
	localparam fwdSelT selWmDm = 4'd12;
	localparam fwdSelT selWmPc = 4'd13;

	// Stage in which an operand is first read
	localparam useTimeT useD = 2'd0;
	localparam useTimeT useE = 2'd1;
	localparam useTimeT useM = 2'd2;
	localparam useTimeT useNone = 2'd3;

endpackage

/* hazardStall.sv */
module hazardStall
	import mipsIsaPkg::*, fwdPkg::*;
(
	input logic [31:0] instrD,
	input logic [31:0] instrE,
	input logic [31:0] instrM,
	output logic stall
);

	logic [4:0] rsD;
	logic [4:0] rtD;
	logic [4:0] a3E;
	logic [4:0] a3M;
	useTimeT tuseRs;
	useTimeT tuseRt;
	useTimeT tnewE;
	useTimeT tnewM;
	resClassT classE;
	resClassT classM;
	logic stallRs;
	logic stallRt;

	instrDecode decD_i (.instr(instrD), .rs(rsD), .rt(rtD), .a3(), .resClass(),
		.tuseRs(tuseRs), .tuseRt(tuseRt));
	instrDecode decE_i (.instr(instrE), .rs(), .rt(), .a3(a3E), .resClass(classE),
		.tuseRs(), .tuseRt());
	instrDecode decM_i (.instr(instrM), .rs(), .rt(), .a3(a3M), .resClass(classM),
		.tuseRs(), .tuseRt());

	// Cycles until the producer reaches a forwarding source
	always_comb begin
		case (classE)
			resAlu: tnewE = 2'd1;
			resDm: tnewE = 2'd2;
			// Link is only forwarded from M onward
			resPc: tnewE = 2'd1;
			default: tnewE = 2'd0;
		endcase
		tnewM = (classM == resDm) ? 2'd1 : 2'd0;
	end

	// Operand needed earlier than its producer can deliver
	assign stallRs = (rsD != '0) &&
		((rsD == a3E && tuseRs < tnewE) || (rsD == a3M && tuseRs < tnewM));
	assign stallRt = (rtD != '0) &&
		((rtD == a3E && tuseRt < tnewE) || (rtD == a3M && tuseRt < tnewM));

	assign stall = stallRs || stallRt;

endmodule

/* instrDecode.sv */
module instrDecode
	import mipsIsaPkg::*, fwdPkg::*;
(
	input logic [31:0] instr,
	output logic [4:0] rs,
	output logic [4:0] rt,
	output logic [4:0] a3,
	output resClassT resClass,
	output useTimeT tuseRs,
	output useTimeT tuseRt
);

	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] rd;

	assign op = instr[opMsb:opLsb];
	assign funct = instr[functMsb:functLsb];
	assign rs = instr[rsMsb:rsLsb];
	assign rt = instr[rtMsb:rtLsb];
	assign rd = instr[rdMsb:rdLsb];

	// Unknown opcodes fall through as no-ops
	always_comb begin
		a3 = '0;
		resClass = resNone;
		tuseRs = useNone;
		tuseRt = useNone;
		case (op)
			opSpecial: begin
				if (funct == functAddu || funct == functSubu) begin
					a3 = rd;
					resClass = resAlu;
					tuseRs = useE;
					tuseRt = useE;
				end
			end
			opOri: begin
				a3 = rt;
				resClass = resAlu;
				tuseRs = useE;
			end
			opLui: begin
				a3 = rt;
				resClass = resAlu;
			end
			opLw: begin
				a3 = rt;
				resClass = resDm;
				tuseRs = useE;
			end
			opSw: begin
				// Base in E, data not until M
				tuseRs = useE;
				tuseRt = useM;
			end
			opBeq: begin
				tuseRs = useD;
				tuseRt = useD;
			end
			opJal: begin
				a3 = linkReg;
				resClass = resPc;
			end
			default: begin
				a3 = '0;
			end
		endcase
	end

endmodule

/* mipsIsaPkg.sv */
package mipsIsaPkg;

	////////////////////
	// Opcodes
	////////////////////

	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// R-type functs, valid only under opSpecial
	localparam logic [5:0] functAddu = 6'h21;
	localparam logic [5:0] functSubu = 6'h23;

	////////////////////
	// Instruction fields
	////////////////////

	localparam int opMsb = 31;
	localparam int opLsb = 26;
	localparam int rsMsb = 25;
	localparam int rsLsb = 21;
	localparam int rtMsb = 20;
	localparam int rtLsb = 16;
	localparam int rdMsb = 15;
	localparam int rdLsb = 11;
	localparam int immMsb = 15;
	localparam int immLsb = 0;
	localparam int functMsb = 5;
	localparam int functLsb = 0;

	// Jump index of jal
	localparam int jIdxMsb = 25;
	localparam int jIdxLsb = 0;

	////////////////////
	// Result timing
	////////////////////

	typedef logic [2:0] resClassT;

	localparam resClassT resNone = 3'd0;
	// Ready at the end of E
	localparam resClassT resAlu = 3'd1;
	// Ready at the end of M
	localparam resClassT resDm = 3'd2;
	// Link value, known from D onward
	localparam resClassT resPc = 3'd3;

	localparam logic [31:0] resetPc = 32'h0000_3000;
	localparam logic [4:0] linkReg = 5'd31;

endpackage

/* pipeCore.sv */
module pipeCore
	import mipsIsaPkg::*, fwdPkg::*;
(
	input logic clk,
	input logic arstN,
	output logic [31:0] instrAddr,
	input logic [31:0] instr,
	output logic [31:0] dmAddr,
	output logic [31:0] dmWrData,
	output logic dmWrEn,
	input logic [31:0] dmRdData,
	output logic wbEn,
	output logic [4:0] wbReg,
	output logic [31:0] wbData
);

	logic [31:0] pcF;
	logic [31:0] pcNext;

	logic [31:0] instrD;
	logic [31:0] pc8D;
	logic [5:0] opD;
	logic [5:0] functD;
	logic [31:0] rd1D;
	logic [31:0] rd2D;
	logic [31:0] cmp1D;
	logic [31:0] cmp2D;
	logic [31:0] extImmD;
	logic [31:0] slotPcD;
	logic [31:0] brTargetD;
	logic [31:0] jTargetD;
	logic branchD;
	logic [4:0] a3D;

	logic [31:0] instrE;
	logic [31:0] pc8E;
	logic [5:0] opE;
	logic [5:0] functE;
	logic [31:0] rsValE;
	logic [31:0] rtValE;
	logic [31:0] immE;
	logic [31:0] aluAE;
	logic [31:0] rtFwdE;
	logic [31:0] aluBE;
	logic [31:0] aluOutE;
	logic [4:0] a3E;

	logic [31:0] instrM;
	logic [31:0] pc8M;
	logic [5:0] opM;
	logic [31:0] aluOutM;
	logic [31:0] rtValM;
	logic [4:0] a3M;

	logic [31:0] instrW;
	logic [31:0] pc8W;
	logic [5:0] opW;
	logic [31:0] aluOutW;
	logic [31:0] dmDataW;
	logic [4:0] a3W;

	fwdSelT cmp1Sel;
	fwdSelT cmp2Sel;
	fwdSelT aluASel;
	fwdSelT aluBSel;
	fwdSelT dmDataSel;
	logic stall;

	// One source mux shared by all five forwarding points
	function automatic logic [31:0] fwdPick(input fwdSelT sel, input logic [31:0] regVal);
		logic [31:0] val;
		case (sel)
			selMdAlu, selMeAlu: val = aluOutM;
			selMdPc, selMePc: val = pc8M;
			selWdAlu, selWeAlu, selWmAlu: val = aluOutW;
			selWdDm, selWeDm, selWmDm: val = dmDataW;
			selWdPc, selWePc, selWmPc: val = pc8W;
			default: val = regVal;
		endcase
		return val;
	endfunction

	forwardControl fwd_i (
		.instrD(instrD),
		.instrE(instrE),
		.instrM(instrM),
		.instrW(instrW),
		.a3M(a3M),
		.a3W(a3W),
		.cmp1Sel(cmp1Sel),
		.cmp2Sel(cmp2Sel),
		.aluASel(aluASel),
		.aluBSel(aluBSel),
		.dmDataSel(dmDataSel)
	);

	hazardStall hz_i (.instrD(instrD), .instrE(instrE), .instrM(instrM), .stall(stall));

	regFile rf_i (
		.clk(clk),
		.arstN(arstN),
		.ra1(instrD[rsMsb:rsLsb]),
		.ra2(instrD[rtMsb:rtLsb]),
		.rd1(rd1D),
		.rd2(rd2D),
		.we(wbEn),
		.wa(a3W),
		.wd(wbData)
	);

	////////////////////
	// Fetch
	////////////////////

	assign instrAddr = pcF;

	always_comb begin
		if (stall) begin
			pcNext = pcF;
		end else if (branchD) begin
			pcNext = brTargetD;
		end else if (opD == opJal) begin
			pcNext = jTargetD;
		end else begin
			pcNext = pcF + 32'd4;
		end
	end

	////////////////////
	// Decode
	////////////////////

	assign opD = instrD[opMsb:opLsb];
	assign functD = instrD[functMsb:functLsb];

	always_comb begin
		cmp1D = fwdPick(cmp1Sel, rd1D);
		cmp2D = fwdPick(cmp2Sel, rd2D);
	end

	// Targets are relative to the delay slot
	assign slotPcD = pc8D - 32'd4;
	assign branchD = (opD == opBeq) && (cmp1D == cmp2D);
	assign brTargetD = slotPcD + {{14{instrD[immMsb]}}, instrD[immMsb:immLsb], 2'b00};
	assign jTargetD = {slotPcD[31:28], instrD[jIdxMsb:jIdxLsb], 2'b00};

	always_comb begin
		case (opD)
			opOri: extImmD = {16'h0000, instrD[immMsb:immLsb]};
			opLui: extImmD = {instrD[immMsb:immLsb], 16'h0000};
			default: extImmD = {{16{instrD[immMsb]}}, instrD[immMsb:immLsb]};
		endcase
	end

	// Zero destination means nothing to write back
	always_comb begin
		a3D = '0;
		case (opD)
			opSpecial: begin
				if (functD == functAddu || functD == functSubu) begin
					a3D = instrD[rdMsb:rdLsb];
				end
			end
			opOri, opLui, opLw: a3D = instrD[rtMsb:rtLsb];
			opJal: a3D = linkReg;
			default: a3D = '0;
		endcase
	end

	////////////////////
	// Execute
	////////////////////

	assign opE = instrE[opMsb:opLsb];
	assign functE = instrE[functMsb:functLsb];

	always_comb begin
		aluAE = fwdPick(aluASel, rsValE);
		rtFwdE = fwdPick(aluBSel, rtValE);
	end

	assign aluBE = (opE == opSpecial) ? rtFwdE : immE;

	always_comb begin
		case (opE)
			opSpecial: aluOutE = (functE == functSubu) ? aluAE - aluBE : aluAE + aluBE;
			opOri: aluOutE = aluAE | aluBE;
			opLui: aluOutE = aluBE;
			// Address add for lw and sw
			default: aluOutE = aluAE + aluBE;
		endcase
	end

	////////////////////
	// Memory and writeback
	////////////////////

	assign opM = instrM[opMsb:opLsb];
	assign dmAddr = aluOutM;
	assign dmWrEn = (opM == opSw);

	always_comb begin
		dmWrData = fwdPick(dmDataSel, rtValM);
	end

	assign opW = instrW[opMsb:opLsb];
	assign wbEn = (a3W != '0);
	assign wbReg = a3W;

	always_comb begin
		case (opW)
			opLw: wbData = dmDataW;
			opJal: wbData = pc8W;
			default: wbData = aluOutW;
		endcase
	end

	// Stall holds PC and D, E takes a bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= resetPc;
			instrD <= '0;
			instrE <= '0;
			a3E <= '0;
			instrM <= '0;
			a3M <= '0;
			instrW <= '0;
			a3W <= '0;
		end else begin
			pcF <= pcNext;
			if (!stall) begin
				instrD <= instr;
			end
			instrE <= stall ? '0 : instrD;
			a3E <= stall ? '0 : a3D;
			instrM <= instrE;
			a3M <= a3E;
			instrW <= instrM;
			a3W <= a3M;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pc8D <= pcF + 32'd8;
		end
		rsValE <= cmp1D;
		rtValE <= cmp2D;
		immE <= extImmD;
		pc8E <= pc8D;
		aluOutM <= aluOutE;
		rtValM <= rtFwdE;
		pc8M <= pc8E;
		aluOutW <= aluOutM;
		dmDataW <= dmRdData;
		pc8W <= pc8M;
	end

	// No store strobe while the pipeline is held in reset
	assert property (@(posedge clk) !arstN |-> !dmWrEn);

	// Worst case is a load feeding a compare, two cycles
	assert property (@(posedge clk) disable iff (!arstN)
		stall && $past(stall) |=> !stall);

endmodule

/* regFile.sv */
module regFile (
	input logic clk,
	input logic arstN,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	input logic we,
	input logic [4:0] wa,
	input logic [31:0] wd
);

	logic [31:0] regs [32];

	// Entry 0 is never written
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Write-through so D sees this cycle's writeback
	always_comb begin
		if (ra1 == '0) begin
			rd1 = '0;
		end else if (we && ra1 == wa) begin
			rd1 = wd;
		end else begin
			rd1 = regs[ra1];
		end

		if (ra2 == '0) begin
			rd2 = '0;
		end else if (we && ra2 == wa) begin
			rd2 = wd;
		end else begin
			rd2 = regs[ra2];
		end
	end

endmodule

/* tb.f */
mipsIsaPkg.sv
fwdPkg.sv
instrDecode.sv
forwardControl.sv
hazardStall.sv
regFile.sv
pipeCore.sv
tbPipeCore.sv

/* tbPipeCore.sv */
module tbPipeCore
	import mipsIsaPkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int progLen = 200;
	localparam logic [31:0] seed = 32'he1cd04c7;

	logic clk;
	logic arstN;
	logic [31:0] instrAddr;
	logic [31:0] instr;
	logic [31:0] dmAddr;
	logic [31:0] dmWrData;
	logic dmWrEn;
	logic [31:0] dmRdData;
	logic wbEn;
	logic [4:0] wbReg;
	logic [31:0] wbData;

	logic [31:0] rngState;
	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] fetchOff;

	// Golden sequences of register writes and stores
	logic [4:0] expWrReg [512];
	logic [31:0] expWrVal [512];
	logic [31:0] expStAddr [512];
	logic [31:0] expStVal [512];
	int nWr;
	int nSt;
	int wrIdx;
	int stIdx;
	int sinceReset;
	int wbErrs;
	int storeErrs;
	int otherErrs;
	logic [4:0] headReg;
	logic [31:0] headData;
	logic [31:0] headAddr;
	logic [31:0] headStore;

	pipeCore dut_i (
		.clk(clk),
		.arstN(arstN),
		.instrAddr(instrAddr),
		.instr(instr),
		.dmAddr(dmAddr),
		.dmWrData(dmWrData),
		.dmWrEn(dmWrEn),
		.dmRdData(dmRdData),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Mostly r0 to r7, now and then the link register
	function automatic logic [4:0] pickReg();
		logic [31:0] r;
		r = nextRand();
		if (r[3:0] == 4'hf) begin
			return 5'd31;
		end
		return {2'b00, r[6:4]};
	endfunction

	function automatic logic [31:0] fillWord(input int idx);
		logic [31:0] a;
		a = 32'(idx);
		return {~a[7:0], a[7:0], a[7:0] ^ 8'h5c, a[7:0] + 8'h3d};
	endfunction

	////////////////////
	// Random program
	////////////////////

	task automatic buildProgram();
		logic [31:0] r;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] off;
		logic [31:0] target;
		int kind;
		int i;
		logic inSlot;
		i = 0;
		inSlot = 1'b0;
		while (i < progLen) begin
			r = nextRand();
			rs = pickReg();
			rt = pickReg();
			rd = pickReg();
			kind = int'(r[2:0]);
			// No control transfer in a delay slot or near the end
			if (inSlot || i > progLen - 3) begin
				kind = kind % 6;
			end
			inSlot = 1'b0;
			case (kind)
				0: imem[i[7:0]] = {opSpecial, rs, rt, rd, 5'd0, functAddu};
				1: imem[i[7:0]] = {opSpecial, rs, rt, rd, 5'd0, functSubu};
				2: imem[i[7:0]] = {opOri, rs, rt, r[31:16]};
				3: imem[i[7:0]] = {opLui, 5'd0, rt, r[31:16]};
				4: imem[i[7:0]] = {opLw, rs, rt, r[31:16]};
				5: imem[i[7:0]] = {opSw, rs, rt, r[31:16]};
				6: begin
					// Same register on both sides gives taken branches
					if (r[8]) begin
						rt = rs;
					end
					off = 16'(int'(r[11:9]) % 6 + 1);
					imem[i[7:0]] = {opBeq, rs, rt, off};
					inSlot = 1'b1;
				end
				default: begin
					target = (resetPc >> 2) + 32'(i + 2 + int'(r[14:12]) % 6);
					imem[i[7:0]] = {opJal, target[25:0]};
					i++;
					imem[i[7:0]] = 32'h0;
				end
			endcase
			i++;
		end
	endtask

	////////////////////
	// Golden model
	////////////////////

	task automatic runGolden();
		logic [31:0] regs [32];
		logic [31:0] gmem [256];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] newNpc;
		logic [31:0] pcIdx;
		logic [31:0] ins;
		logic [31:0] sext;
		logic [31:0] addr;
		logic [31:0] val;
		logic [31:0] slot;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] dst;
		for (int k = 0; k < 32; k++) begin
			regs[k[4:0]] = 32'h0;
		end
		for (int k = 0; k < 256; k++) begin
			gmem[k[7:0]] = fillWord(k);
		end
		nWr = 0;
		nSt = 0;
		pc = resetPc;
		npc = resetPc + 32'd4;
		while (pc < resetPc + 32'(progLen * 4)) begin
			pcIdx = (pc - resetPc) >> 2;
			ins = imem[pcIdx[7:0]];
			rs = ins[25:21];
			rt = ins[20:16];
			sext = {{16{ins[15]}}, ins[15:0]};
			slot = pc + 32'd4;
			newNpc = npc + 32'd4;
			dst = 5'd0;
			val = 32'h0;
			case (ins[31:26])
				opSpecial: begin
					if (ins[5:0] == functAddu) begin
						dst = ins[15:11];
						val = regs[rs] + regs[rt];
					end else if (ins[5:0] == functSubu) begin
						dst = ins[15:11];
						val = regs[rs] - regs[rt];
					end
				end
				opOri: begin
					dst = rt;
					val = regs[rs] | {16'h0, ins[15:0]};
				end
				opLui: begin
					dst = rt;
					val = {ins[15:0], 16'h0};
				end
				opLw: begin
					addr = regs[rs] + sext;
					dst = rt;
					val = gmem[addr[9:2]];
				end
				opSw: begin
					addr = regs[rs] + sext;
					gmem[addr[9:2]] = regs[rt];
					expStAddr[nSt[8:0]] = addr;
					expStVal[nSt[8:0]] = regs[rt];
					nSt++;
				end
				opBeq: begin
					if (regs[rs] == regs[rt]) begin
						newNpc = slot + (sext << 2);
					end
				end
				opJal: begin
					dst = 5'd31;
					val = pc + 32'd8;
					newNpc = {slot[31:28], ins[25:0], 2'b00};
				end
				default: begin
				end
			endcase
			// r0 stays zero and writes to it never show up
			if (dst != 5'd0) begin
				regs[dst] = val;
				expWrReg[nWr[8:0]] = dst;
				expWrVal[nWr[8:0]] = val;
				nWr++;
			end
			pc = npc;
			npc = newNpc;
		end
	endtask

	task automatic reportCounts();
		$display("Errors: register writes %0d, stores %0d, other %0d (%0d writes, %0d stores)",
			wbErrs, storeErrs, otherErrs, wrIdx, stIdx);
	endtask

	////////////////////
	// Memories
	////////////////////

	assign fetchOff = (instrAddr - resetPc) >> 2;
	assign instr = (fetchOff < 32'd256) ? imem[fetchOff[7:0]] : 32'h0;
	assign dmRdData = dmem[dmAddr[9:2]];

	always @(posedge clk) begin
		if (arstN && dmWrEn) begin
			dmem[dmAddr[9:2]] <= dmWrData;
		end
	end

	////////////////////
	// Checking
	////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrIdx <= 0;
			stIdx <= 0;
			sinceReset <= 0;
		end else begin
			if (wbEn) begin
				wrIdx <= wrIdx + 1;
			end
			if (dmWrEn) begin
				stIdx <= stIdx + 1;
			end
			if (sinceReset < 15) begin
				sinceReset <= sinceReset + 1;
			end
		end
	end

	always_comb begin
		headReg = expWrReg[wrIdx[8:0]];
		headData = expWrVal[wrIdx[8:0]];
		headAddr = expStAddr[stIdx[8:0]];
		headStore = expStVal[stIdx[8:0]];
	end

	assert property (@(posedge clk) !arstN |-> (!wbEn && !dmWrEn))
		else begin
			otherErrs++;
			$display("Write or store strobe seen while reset is asserted");
		end
	// First fetch needs four edges to reach W and three to reach M
	assert property (@(posedge clk) disable iff (!arstN) (sinceReset < 4) |-> !wbEn)
		else begin
			otherErrs++;
			$display("Register write before the first instruction reached W");
		end
	assert property (@(posedge clk) disable iff (!arstN) (sinceReset < 3) |-> !dmWrEn)
		else begin
			otherErrs++;
			$display("Store before the first instruction reached M");
		end
	assert property (@(posedge clk) disable iff (!arstN) wbEn |-> (wrIdx < nWr))
		else begin
			otherErrs++;
			$display("Register write to r%0d beyond the expected %0d writes",
				$sampled(wbReg), nWr);
		end
	assert property (@(posedge clk) disable iff (!arstN)
		(wbEn && wrIdx < nWr) |-> (wbReg == headReg))
		else begin
			wbErrs++;
			$display("ERR wbReg got %h expected %h at write %0d",
				$sampled(wbReg), $sampled(headReg), $sampled(wrIdx));
		end
	assert property (@(posedge clk) disable iff (!arstN)
		(wbEn && wrIdx < nWr) |-> (wbData == headData))
		else begin
			wbErrs++;
			$display("ERR wbData got %h expected %h at write %0d",
				$sampled(wbData), $sampled(headData), $sampled(wrIdx));
		end
	assert property (@(posedge clk) disable iff (!arstN) dmWrEn |-> (stIdx < nSt))
		else begin
			otherErrs++;
			$display("Store beyond the expected %0d stores", nSt);
		end
	assert property (@(posedge clk) disable iff (!arstN)
		(dmWrEn && stIdx < nSt) |-> (dmAddr == headAddr))
		else begin
			storeErrs++;
			$display("ERR dmAddr got %h expected %h at store %0d",
				$sampled(dmAddr), $sampled(headAddr), $sampled(stIdx));
		end
	assert property (@(posedge clk) disable iff (!arstN)
		(dmWrEn && stIdx < nSt) |-> (dmWrData == headStore))
		else begin
			storeErrs++;
			$display("ERR dmWrData got %h expected %h at store %0d",
				$sampled(dmWrData), $sampled(headStore), $sampled(stIdx));
		end

	////////////////////
	// Clock, stimulus and watchdog
	////////////////////

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		arstN = 1'b0;
		rngState = seed;
		wbErrs = 0;
		storeErrs = 0;
		otherErrs = 0;
		for (int k = 0; k < 256; k++) begin
			imem[k[7:0]] = 32'h0;
			dmem[k[7:0]] = fillWord(k);
		end
		buildProgram();
		runGolden();
		repeat (5) @(posedge clk);
		arstN <= 1'b1;
		while (wrIdx < nWr || stIdx < nSt) begin
			@(posedge clk);
		end
		// Drain so that stray writes after the last one are caught
		repeat (10) @(posedge clk);
		reportCounts();
		if (wbErrs + storeErrs + otherErrs == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Worst case is two stall cycles for every instruction
	initial begin
		repeat (5 + progLen * 3 + 50) @(posedge clk);
		$display("Timeout with %0d of %0d writes and %0d of %0d stores seen",
			wrIdx, nWr, stIdx, nSt);
		reportCounts();
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule
